/* hw/tile_pkg.sv */
package tile_pkg;

  localparam int XLEN = 32;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            write;
  } bus_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            error;
  } bus_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic            last;
  } noc_flit_t;

  // Region is addr[31:28]
  typedef enum logic [3:0] {
    REGION_DMEM = 4'h0,
    REGION_NA   = 4'he,
    REGION_BOOT = 4'hf
  } region_e;

  // Adapter register byte offsets, decoded from addr[3:2]
  localparam logic [3:0] NA_TX      = 4'h0;
  localparam logic [3:0] NA_TX_LAST = 4'h4;
  localparam logic [3:0] NA_RX      = 4'h8;
  localparam logic [3:0] NA_STATUS  = 4'hc;

  localparam int BOOT_WORDS = 8;

  localparam logic [XLEN-1:0] boot_image [BOOT_WORDS] = '{
    32'h0000_0093, 32'h0000_0113, 32'he000_01b7, 32'h0041_a023,
    32'h0081_a283, 32'h00c1_a303, 32'h0000_006f, 32'h0010_0073
  };

endpackage

/* hw/tile_bus.sv */
`timescale 1ns/1ps

module tile_bus (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  tile_pkg::bus_req_t req_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output tile_pkg::bus_rsp_t rsp_o,
  output tile_pkg::bus_req_t slv_req_o,
  output logic               dmem_sel_o,
  output logic               boot_sel_o,
  output logic               na_sel_o,
  input  logic               dmem_done_i,
  input  logic               boot_done_i,
  input  logic               na_done_i,
  input  tile_pkg::bus_rsp_t dmem_rsp_i,
  input  tile_pkg::bus_rsp_t boot_rsp_i,
  input  tile_pkg::bus_rsp_t na_rsp_i
);

  logic               busy_q;
  logic               rsp_valid_q;
  tile_pkg::bus_req_t req_q;
  tile_pkg::bus_rsp_t rsp_q;
  logic               dmem_sel_q;
  logic               boot_sel_q;
  logic               na_sel_q;
  logic               req_fire;
  logic [3:0]         req_region;
  logic               hit_dmem;
  logic               hit_boot;
  logic               hit_na;
  logic               mapped;
  logic               any_done;
  tile_pkg::bus_rsp_t done_rsp;

  assign req_ready_o = !busy_q && !rsp_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;

  assign req_region = req_i.addr[tile_pkg::XLEN-1 -: 4];
  assign hit_dmem   = req_region == tile_pkg::REGION_DMEM;
  assign hit_boot   = req_region == tile_pkg::REGION_BOOT;
  assign hit_na     = req_region == tile_pkg::REGION_NA;
  assign mapped     = hit_dmem || hit_boot || hit_na;

  // Only the strobed slave can answer
  assign any_done = dmem_done_i || boot_done_i || na_done_i;

  always_comb begin
    done_rsp = na_rsp_i;
    if (dmem_done_i) begin
      done_rsp = dmem_rsp_i;
    end else if (boot_done_i) begin
      done_rsp = boot_rsp_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
      dmem_sel_q  <= 1'b0;
      boot_sel_q  <= 1'b0;
      na_sel_q    <= 1'b0;
    end else begin
      dmem_sel_q <= req_fire && hit_dmem;
      boot_sel_q <= req_fire && hit_boot;
      na_sel_q   <= req_fire && hit_na;
      if (req_fire && mapped) begin
        busy_q <= 1'b1;
      end else if (any_done) begin
        busy_q <= 1'b0;
      end
      if ((req_fire && !mapped) || any_done) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q <= req_i;
    end
    // Unmapped region answers on its own
    if (req_fire && !mapped) begin
      rsp_q <= '{rdata: '0, error: 1'b1};
    end else if (any_done) begin
      rsp_q <= done_rsp;
    end
  end

  assign slv_req_o   = req_q;
  assign dmem_sel_o  = dmem_sel_q;
  assign boot_sel_o  = boot_sel_q;
  assign na_sel_o    = na_sel_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  a_done_outstanding: assert property (@(posedge clk) disable iff (reset_i)
    any_done |-> busy_q);

endmodule

/* hw/tile_dmem.sv */
`timescale 1ns/1ps

module tile_dmem #(
  parameter int MEM_WORDS = 256
) (
  input  logic               clk,
  input  logic               reset_i,
  input  tile_pkg::bus_req_t req_i,
  input  logic               sel_i,
  output logic               done_o,
  output tile_pkg::bus_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [tile_pkg::XLEN-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]          idx;
  logic                      done_q;
  tile_pkg::bus_rsp_t        rsp_q;

  // Upper address bits alias
  assign idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (sel_i) begin
      if (req_i.write) begin
        mem[idx]    <= req_i.wdata;
        rsp_q.rdata <= '0;
      end else begin
        rsp_q.rdata <= mem[idx];
      end
      rsp_q.error <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= sel_i;
    end
  end

  assign done_o = done_q;
  assign rsp_o  = rsp_q;

endmodule

/* hw/tile_bootrom.sv */
`timescale 1ns/1ps

module tile_bootrom (
  input  logic               clk,
  input  logic               reset_i,
  input  tile_pkg::bus_req_t req_i,
  input  logic               sel_i,
  output logic               done_o,
  output tile_pkg::bus_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(tile_pkg::BOOT_WORDS);

  logic [IDX_W-1:0]   idx;
  logic               done_q;
  tile_pkg::bus_rsp_t rsp_q;

  assign idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (sel_i) begin
      if (req_i.write) begin
        rsp_q <= '{rdata: '0, error: 1'b1};
      end else begin
        rsp_q <= '{rdata: tile_pkg::boot_image[idx], error: 1'b0};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= sel_i;
    end
  end

  assign done_o = done_q;
  assign rsp_o  = rsp_q;

endmodule

/* hw/noc_rx_fifo.sv */
`timescale 1ns/1ps

module noc_rx_fifo #(
  parameter int RX_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       push_i,
  input  tile_pkg::noc_flit_t        push_flit_i,
  output logic                       full_o,
  input  logic                       pop_i,
  output tile_pkg::noc_flit_t        head_o,
  output logic                       empty_o,
  output logic [$clog2(RX_DEPTH):0]  count_o
);

  localparam int PTR_W = $clog2(RX_DEPTH);

  tile_pkg::noc_flit_t mem [RX_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [PTR_W:0]      count;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_flit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_i);
    end
  end

  assign head_o  = mem[rd_ptr];
  assign full_o  = count == RX_DEPTH;
  assign empty_o = count == 0;
  assign count_o = count;

  a_no_overrun: assert property (@(posedge clk) disable iff (reset_i)
    !(push_i && full_o) && !(pop_i && empty_o));

endmodule

/* hw/noc_adapter.sv */
`timescale 1ns/1ps

module noc_adapter #(
  parameter int RX_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset_i,
  input  tile_pkg::bus_req_t  req_i,
  input  logic                sel_i,
  output logic                done_o,
  output tile_pkg::bus_rsp_t  rsp_o,
  output logic                noc_out_valid_o,
  input  logic                noc_out_ready_i,
  output tile_pkg::noc_flit_t noc_out_flit_o,
  input  logic                noc_in_valid_i,
  output logic                noc_in_ready_o,
  input  tile_pkg::noc_flit_t noc_in_flit_i
);

  localparam int CNT_W = $clog2(RX_DEPTH) + 1;

  logic [3:0]          offset;
  logic                tx_write;
  logic                rx_pop;
  logic                rx_full;
  logic                rx_empty;
  logic [CNT_W-1:0]    rx_count;
  tile_pkg::noc_flit_t rx_head;
  logic                tx_valid_q;
  tile_pkg::noc_flit_t tx_flit_q;
  logic                done_q;
  tile_pkg::bus_rsp_t  rsp_q;

  assign offset   = {req_i.addr[3:2], 2'b00};
  assign tx_write = sel_i && req_i.write &&
                    (offset == tile_pkg::NA_TX || offset == tile_pkg::NA_TX_LAST);
  assign rx_pop   = sel_i && !req_i.write && offset == tile_pkg::NA_RX && !rx_empty;

  noc_rx_fifo #(
    .RX_DEPTH (RX_DEPTH)
  ) u_rx_fifo (
    .clk         (clk),
    .reset_i     (reset_i),
    .push_i      (noc_in_valid_i && !rx_full),
    .push_flit_i (noc_in_flit_i),
    .full_o      (rx_full),
    .pop_i       (rx_pop),
    .head_o      (rx_head),
    .empty_o     (rx_empty),
    .count_o     (rx_count)
  );

  assign noc_in_ready_o = !rx_full;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      tx_valid_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= sel_i && !tx_write;
      if (tx_write) begin
        tx_valid_q <= 1'b1;
      end else if (noc_out_ready_i) begin
        tx_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_write) begin
      tx_flit_q <= '{data: req_i.wdata, last: offset == tile_pkg::NA_TX_LAST};
    end
    if (sel_i) begin
      rsp_q <= '{rdata: '0, error: 1'b0};
      case (offset)
        tile_pkg::NA_RX: begin
          if (req_i.write || rx_empty) begin
            rsp_q.error <= 1'b1;
          end else begin
            rsp_q.rdata <= rx_head.data;
          end
        end
        tile_pkg::NA_STATUS: begin
          if (req_i.write) begin
            rsp_q.error <= 1'b1;
          end else begin
            // Head last flag in bit 31, occupancy below
            rsp_q.rdata <= {rx_head.last && !rx_empty,
                            {(tile_pkg::XLEN-1-CNT_W){1'b0}}, rx_count};
          end
        end
        default: ;
      endcase
    end
  end

  // TX response waits for the flit to leave
  assign done_o          = done_q || (tx_valid_q && noc_out_ready_i);
  assign rsp_o           = rsp_q;
  assign noc_out_valid_o = tx_valid_q;
  assign noc_out_flit_o  = tx_flit_q;

  a_tx_stable: assert property (@(posedge clk) disable iff (reset_i)
    noc_out_valid_o && !noc_out_ready_i |=> noc_out_valid_o && $stable(noc_out_flit_o));

endmodule

/* hw/tile_top.sv */
`timescale 1ns/1ps

module tile_top #(
  parameter int MEM_WORDS = 256,
  parameter int RX_DEPTH  = 4
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  tile_pkg::bus_req_t  req_i,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output tile_pkg::bus_rsp_t  rsp_o,
  output logic                noc_out_valid_o,
  input  logic                noc_out_ready_i,
  output tile_pkg::noc_flit_t noc_out_flit_o,
  input  logic                noc_in_valid_i,
  output logic                noc_in_ready_o,
  input  tile_pkg::noc_flit_t noc_in_flit_i
);

  tile_pkg::bus_req_t slv_req;
  tile_pkg::bus_rsp_t dmem_rsp;
  tile_pkg::bus_rsp_t boot_rsp;
  tile_pkg::bus_rsp_t na_rsp;
  logic               dmem_sel;
  logic               boot_sel;
  logic               na_sel;
  logic               dmem_done;
  logic               boot_done;
  logic               na_done;

  tile_bus u_bus (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .slv_req_o   (slv_req),
    .dmem_sel_o  (dmem_sel),
    .boot_sel_o  (boot_sel),
    .na_sel_o    (na_sel),
    .dmem_done_i (dmem_done),
    .boot_done_i (boot_done),
    .na_done_i   (na_done),
    .dmem_rsp_i  (dmem_rsp),
    .boot_rsp_i  (boot_rsp),
    .na_rsp_i    (na_rsp)
  );

  tile_dmem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_dmem (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (slv_req),
    .sel_i   (dmem_sel),
    .done_o  (dmem_done),
    .rsp_o   (dmem_rsp)
  );

  tile_bootrom u_bootrom (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (slv_req),
    .sel_i   (boot_sel),
    .done_o  (boot_done),
    .rsp_o   (boot_rsp)
  );

  noc_adapter #(
    .RX_DEPTH (RX_DEPTH)
  ) u_na (
    .clk             (clk),
    .reset_i         (reset_i),
    .req_i           (slv_req),
    .sel_i           (na_sel),
    .done_o          (na_done),
    .rsp_o           (na_rsp),
    .noc_out_valid_o (noc_out_valid_o),
    .noc_out_ready_i (noc_out_ready_i),
    .noc_out_flit_o  (noc_out_flit_o),
    .noc_in_valid_i  (noc_in_valid_i),
    .noc_in_ready_o  (noc_in_ready_o),
    .noc_in_flit_i   (noc_in_flit_i)
  );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    reset_o = 1'b0;
  end

endmodule

/* sim/tile_checker.sv */
`timescale 1ns/1ps

module tile_checker #(
  parameter int MEM_WORDS = 256,
  parameter int RX_DEPTH  = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_valid_i,
  input  logic                req_ready_i,
  input  tile_pkg::bus_req_t  req_i,
  input  logic                rsp_valid_i,
  input  logic                rsp_ready_i,
  input  tile_pkg::bus_rsp_t  rsp_i,
  input  logic                out_valid_i,
  input  logic                out_ready_i,
  input  tile_pkg::noc_flit_t out_flit_i,
  input  logic                in_valid_i,
  input  logic                in_ready_i,
  input  tile_pkg::noc_flit_t in_flit_i,
  output int                  pass_count_o,
  output int                  fail_count_o,
  output int                  outstanding_o,
  output logic                timeout_o
);

  // About 300 transactions of at most 40 cycles each
  localparam int TIMEOUT_CYCLES = 300 * 40;

  logic [31:0]         shadow [int];
  tile_pkg::bus_rsp_t  exp_rsp [$];
  bit                  exp_is_tx [$];
  tile_pkg::noc_flit_t exp_flit [$];
  tile_pkg::noc_flit_t rx_model [$];
  tile_pkg::bus_rsp_t  held_rsp;
  bit                  held = 1'b0;
  bit                  pop_pend = 1'b0;
  bit                  in_reset = 1'b0;
  int                  cycles = 0;
  int                  pass_count = 0;
  int                  fail_count = 0;
  int                  outstanding = 0;

  assign pass_count_o  = pass_count;
  assign fail_count_o  = fail_count;
  assign outstanding_o = outstanding;
  assign timeout_o     = cycles >= TIMEOUT_CYCLES;

  task automatic check_value(string name, logic [32:0] exp, logic [32:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_error(string what);
    $display("error: %s at %0t", what, $time);
    fail_count++;
  endtask

  function automatic int dmem_index(logic [31:0] addr);
    return int'((addr >> 2) % MEM_WORDS);
  endfunction

  function automatic tile_pkg::bus_rsp_t expected_rsp(tile_pkg::bus_req_t req);
    tile_pkg::bus_rsp_t rsp;
    logic [3:0]         offset;
    int                 idx;
    rsp    = '{rdata: '0, error: 1'b0};
    offset = {req.addr[3:2], 2'b00};
    idx    = dmem_index(req.addr);
    case (req.addr[31:28])
      tile_pkg::REGION_DMEM: begin
        if (!req.write) begin
          rsp.rdata = shadow.exists(idx) ? shadow[idx] : 'x;
        end
      end
      tile_pkg::REGION_BOOT: begin
        if (req.write) begin
          rsp.error = 1'b1;
        end else begin
          rsp.rdata = tile_pkg::boot_image[req.addr[4:2]];
        end
      end
      tile_pkg::REGION_NA: begin
        if (offset == tile_pkg::NA_RX) begin
          if (req.write || rx_model.size() == 0) begin
            rsp.error = 1'b1;
          end else begin
            rsp.rdata = rx_model[0].data;
          end
        end else if (offset == tile_pkg::NA_STATUS) begin
          if (req.write) begin
            rsp.error = 1'b1;
          end else begin
            rsp.rdata = 32'(rx_model.size());
            if (rx_model.size() != 0) begin
              rsp.rdata[31] = rx_model[0].last;
            end
          end
        end
      end
      default: rsp.error = 1'b1;
    endcase
    return rsp;
  endfunction

  task automatic watch_rx_side();
    logic exp_ready;
    // DUT pops one cycle after the model does
    exp_ready = (rx_model.size() + int'(pop_pend)) < RX_DEPTH;
    if (in_valid_i) begin
      check_value("noc_in_ready_o", exp_ready, in_ready_i);
    end
    pop_pend = 1'b0;
    if (in_valid_i && in_ready_i) begin
      rx_model.push_back(in_flit_i);
    end
  endtask

  task automatic watch_flit();
    tile_pkg::noc_flit_t exp;
    if (out_valid_i && out_ready_i) begin
      if (exp_flit.size() == 0) begin
        report_error("flit sent with no TX write behind it");
      end else begin
        exp = exp_flit.pop_front();
        check_value("noc_out_flit_o.data", exp.data, out_flit_i.data);
        check_value("noc_out_flit_o.last", exp.last, out_flit_i.last);
      end
    end
  endtask

  task automatic watch_response();
    tile_pkg::bus_rsp_t exp;
    if (held) begin
      if (!rsp_valid_i) begin
        report_error("response dropped before the master took it");
      end else begin
        check_value("rsp_o", held_rsp, rsp_i);
      end
    end
    // A TX response must not appear while its flit is still waiting
    if (rsp_valid_i && !held && exp_is_tx.size() != 0) begin
      if (exp_is_tx[0] && exp_flit.size() != 0) begin
        report_error("TX write answered before its flit was accepted");
      end
    end
    if (rsp_valid_i && req_ready_i) begin
      report_error("req_ready_o high while a response is held");
    end
    held     = rsp_valid_i && !rsp_ready_i;
    held_rsp = rsp_i;
    if (rsp_valid_i && rsp_ready_i) begin
      if (exp_rsp.size() == 0) begin
        report_error("response arrived with no request outstanding");
      end else begin
        exp = exp_rsp.pop_front();
        void'(exp_is_tx.pop_front());
        check_value("rsp_o.rdata", exp.rdata, rsp_i.rdata);
        check_value("rsp_o.error", exp.error, rsp_i.error);
      end
    end
  endtask

  task automatic log_request();
    tile_pkg::bus_req_t  req;
    tile_pkg::noc_flit_t flit;
    logic [3:0]          offset;
    logic [3:0]          region;
    bit                  is_tx;
    req    = req_i;
    offset = {req.addr[3:2], 2'b00};
    region = req.addr[31:28];
    is_tx  = req.write && region == tile_pkg::REGION_NA &&
             (offset == tile_pkg::NA_TX || offset == tile_pkg::NA_TX_LAST);
    exp_rsp.push_back(expected_rsp(req));
    exp_is_tx.push_back(is_tx);
    if (is_tx) begin
      flit = '{data: req.wdata, last: offset == tile_pkg::NA_TX_LAST};
      exp_flit.push_back(flit);
    end
    if (req.write && region == tile_pkg::REGION_DMEM) begin
      shadow[dmem_index(req.addr)] = req.wdata;
    end
    if (!req.write && region == tile_pkg::REGION_NA && offset == tile_pkg::NA_RX &&
        rx_model.size() != 0) begin
      void'(rx_model.pop_front());
      pop_pend = 1'b1;
    end
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (reset_i) begin
      in_reset = 1'b1;
    end else begin
      // First edge after reset shows the idle state
      if (in_reset) begin
        check_value("rsp_valid_o", 1'b0, rsp_valid_i);
        check_value("noc_out_valid_o", 1'b0, out_valid_i);
        check_value("req_ready_o", 1'b1, req_ready_i);
        in_reset = 1'b0;
      end
      watch_rx_side();
      watch_flit();
      watch_response();
      if (req_valid_i && req_ready_i) begin
        log_request();
      end
    end
    outstanding = exp_rsp.size() + exp_flit.size();
  end

endmodule

/* sim/tile_tb.sv */
`timescale 1ns/1ps

module tile_tb;

  localparam int MEM_WORDS = 256;
  localparam int RX_DEPTH  = 4;

  logic                clk;
  logic                reset;
  logic                req_valid;
  logic                req_ready;
  tile_pkg::bus_req_t  req;
  logic                rsp_valid;
  logic                rsp_ready;
  tile_pkg::bus_rsp_t  rsp;
  logic                noc_out_valid;
  logic                noc_out_ready;
  tile_pkg::noc_flit_t noc_out_flit;
  logic                noc_in_valid;
  logic                noc_in_ready;
  tile_pkg::noc_flit_t noc_in_flit;
  int                  pass_count;
  int                  fail_count;
  int                  outstanding;
  logic                timeout;
  int                  rsp_stall;
  int                  out_stall;
  int                  test_num;
  int                  fails_before;
  int                  written [$];

  tb_clock #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (2)
  ) u_clock (
    .clk_o   (clk),
    .reset_o (reset)
  );

  tile_top #(
    .MEM_WORDS (MEM_WORDS),
    .RX_DEPTH  (RX_DEPTH)
  ) UUT (
    .clk             (clk),
    .reset_i         (reset),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .req_i           (req),
    .rsp_valid_o     (rsp_valid),
    .rsp_ready_i     (rsp_ready),
    .rsp_o           (rsp),
    .noc_out_valid_o (noc_out_valid),
    .noc_out_ready_i (noc_out_ready),
    .noc_out_flit_o  (noc_out_flit),
    .noc_in_valid_i  (noc_in_valid),
    .noc_in_ready_o  (noc_in_ready),
    .noc_in_flit_i   (noc_in_flit)
  );

  tile_checker #(
    .MEM_WORDS (MEM_WORDS),
    .RX_DEPTH  (RX_DEPTH)
  ) u_checker (
    .clk_i         (clk),
    .reset_i       (reset),
    .req_valid_i   (req_valid),
    .req_ready_i   (req_ready),
    .req_i         (req),
    .rsp_valid_i   (rsp_valid),
    .rsp_ready_i   (rsp_ready),
    .rsp_i         (rsp),
    .out_valid_i   (noc_out_valid),
    .out_ready_i   (noc_out_ready),
    .out_flit_i    (noc_out_flit),
    .in_valid_i    (noc_in_valid),
    .in_ready_i    (noc_in_ready),
    .in_flit_i     (noc_in_flit),
    .pass_count_o  (pass_count),
    .fail_count_o  (fail_count),
    .outstanding_o (outstanding),
    .timeout_o     (timeout)
  );

  // Random back-pressure on both outgoing channels
  always @(posedge clk) begin
    #2;
    rsp_ready     = $urandom_range(99) >= rsp_stall;
    noc_out_ready = $urandom_range(99) >= out_stall;
  end

  // Word index with random aliasing bits above the memory size
  function automatic logic [31:0] dmem_addr(int idx);
    logic [31:0] upper;
    upper = $urandom & 32'h0fff_ffff & ~32'(MEM_WORDS * 4 - 1);
    return upper | 32'(idx << 2);
  endfunction

  task automatic bus_access(logic [31:0] addr, logic [31:0] wdata, logic write);
    req       = '{addr: addr, wdata: wdata, write: write};
    req_valid = 1'b1;
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic push_flit(logic [31:0] data, logic last);
    noc_in_flit  = '{data: data, last: last};
    noc_in_valid = 1'b1;
    @(posedge clk);
    while (!noc_in_ready) @(posedge clk);
    #2;
    noc_in_valid = 1'b0;
  endtask

  // Offered while the FIFO is full, so it must not be taken
  task automatic offer_blocked_flit(logic [31:0] data);
    noc_in_flit  = '{data: data, last: 1'b1};
    noc_in_valid = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    noc_in_valid = 1'b0;
  endtask

  task automatic end_test(string name);
    int fails;
    while (outstanding != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    fails = fail_count - fails_before;
    test_num++;
    if (fails == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, fails);
    end
    fails_before = fail_count;
    #2;
  endtask

  initial begin
    wait (timeout);
    $display("timeout: cycle limit reached with %0d items pending", outstanding);
    $display("sim failed");
    $finish;
  end

  initial begin
    int idx;
    void'($urandom(32'he885_f16f));
    req_valid     = 1'b0;
    req           = '0;
    rsp_ready     = 1'b1;
    noc_out_ready = 1'b1;
    noc_in_valid  = 1'b0;
    noc_in_flit   = '0;
    rsp_stall     = 0;
    out_stall     = 0;
    test_num      = 0;
    fails_before  = 0;
    wait (!reset);
    @(posedge clk);
    #2;
    end_test("reset state");

    rsp_stall = 30;
    for (int i = 0; i < 32; i++) begin
      idx = $urandom_range(MEM_WORDS - 1);
      written.push_back(idx);
      bus_access(dmem_addr(idx), $urandom, 1'b1);
    end
    for (int i = 0; i < 80; i++) begin
      if ($urandom_range(2) == 0) begin
        idx = $urandom_range(MEM_WORDS - 1);
        written.push_back(idx);
        bus_access(dmem_addr(idx), $urandom, 1'b1);
      end else begin
        idx = written[$urandom_range(written.size() - 1)];
        bus_access(dmem_addr(idx), '0, 1'b0);
      end
    end
    end_test("data memory");

    for (int i = 0; i < 8; i++) begin
      bus_access(32'hf000_0000 | ($urandom & 32'h0fff_ffe0) | 32'(i << 2), '0, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      bus_access(32'hf000_0000 | ($urandom & 32'h0fff_fffc), $urandom, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      idx = $urandom_range(13, 1);
      bus_access({4'(idx), 28'($urandom) & 28'hfff_fffc}, $urandom, 1'($urandom));
    end
    end_test("boot rom and unmapped");

    out_stall = 50;
    for (int i = 0; i < 24; i++) begin
      bus_access($urandom_range(1) ? 32'he000_0004 : 32'he000_0000, $urandom, 1'b1);
    end
    bus_access(32'he000_0000, '0, 1'b0);
    bus_access(32'he000_0004, '0, 1'b0);
    end_test("noc transmit");

    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < RX_DEPTH; k++) begin
        push_flit($urandom, 1'($urandom));
      end
      offer_blocked_flit($urandom);
      bus_access(32'he000_000c, '0, 1'b0);
      for (int k = 0; k < RX_DEPTH; k++) begin
        bus_access(32'he000_0008, '0, 1'b0);
        bus_access(32'he000_000c, '0, 1'b0);
      end
      bus_access(32'he000_0008, '0, 1'b0);
      bus_access(32'he000_0008, $urandom, 1'b1);
      bus_access(32'he000_000c, $urandom, 1'b1);
    end
    end_test("noc receive");

    rsp_stall = 80;
    out_stall = 0;
    for (int i = 0; i < 20; i++) begin
      idx = written[$urandom_range(written.size() - 1)];
      case ($urandom_range(2))
        0: bus_access(dmem_addr(idx), $urandom, 1'b1);
        1: bus_access(dmem_addr(idx), '0, 1'b0);
        default: bus_access(32'hf000_0000 | 32'($urandom_range(7) << 2), '0, 1'b0);
      endcase
    end
    end_test("response stalls");

    $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* project.f */
hw/tile_pkg.sv
hw/tile_bus.sv
hw/tile_dmem.sv
hw/tile_bootrom.sv
hw/noc_rx_fifo.sv
hw/noc_adapter.sv
hw/tile_top.sv
sim/tb_clock.sv
sim/tile_checker.sv
sim/tile_tb.sv
